//--- verilog/regex_pkg.sv
// regex coprocessor shared definitions
// widths, buffer depths, the wildcard code, the memory word view
// and the fetcher state encoding
package regex_pkg;

    // character and memory geometry
    localparam int CHAR_WIDTH      = 8;
    localparam int MEM_WIDTH       = 16;
    localparam int CHARS_PER_WORD  = MEM_WIDTH / CHAR_WIDTH;
    localparam int MEM_ADDR_WIDTH  = 11;
    localparam int PTR_WIDTH       = 32;

    // literal pattern limits
    localparam int PATTERN_LEN_MAX   = 4;
    localparam int PATTERN_LEN_WIDTH = 3;

    // character buffer between fetcher and matcher
    localparam int FIFO_DEPTH = 4;

    // ascii dot, matches any character
    localparam logic [CHAR_WIDTH-1:0] WILDCARD_CHAR = 8'h2e;

    // one memory word, seen either whole or as characters
    // character 0 sits in the low byte
    typedef union packed {
        logic [MEM_WIDTH-1:0]                       word;
        logic [CHARS_PER_WORD-1:0][CHAR_WIDTH-1:0]  chars;
    } memory_word_t;

    // job control states of the fetcher
    typedef enum logic [2:0] {
        st_idle,
        st_wait_data,
        st_send,
        st_fetch,
        st_error
    } fetch_state_t;

endpackage

//--- verilog/char_link_if.sv
// four-phase character link
// the source raises req with ch and last stable, the sink answers with ack
interface char_link_if
    import regex_pkg::*;
();

    logic                   req;
    logic                   ack;
    logic [CHAR_WIDTH-1:0]  ch;
    // set on the final character of the string
    logic                   last;

    modport source (
        output req,
        output ch,
        output last,
        input  ack
    );

    modport sink (
        input  req,
        input  ch,
        input  last,
        output ack
    );

endinterface

//--- verilog/char_fetcher.sv
// character fetcher
// accepts a job, reads the text memory one word at a time and
// sends the string out one character per four-phase handshake
module char_fetcher
    import regex_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        valid,
    output logic                        ready,
    input  logic [PTR_WIDTH-1:0]        start_cc_pointer,
    input  logic [PTR_WIDTH-1:0]        end_cc_pointer,

    output logic                        memory_valid,
    output logic [MEM_ADDR_WIDTH-1:0]   memory_addr,
    input  logic                        memory_ready,
    input  memory_word_t                memory_data,

    input  logic                        job_done,
    output logic                        error,

    char_link_if.source                 fetch
);

    fetch_state_t                           state_q;
    // pointer to the character being sent
    logic [PTR_WIDTH-1:0]                   ptr_q;
    // latched memory word, no reset needed
    memory_word_t                           word_q;
    logic                                   req_q;
    // final character handed over, wait for the matcher to finish
    logic                                   sent_last_q;
    logic [$clog2(CHARS_PER_WORD)-1:0]      offset;
    logic                                   at_last;
    logic                                   job_ok;

    // position of the current character inside its word
    assign offset  = ptr_q[$clog2(CHARS_PER_WORD)-1:0];
    assign at_last = (ptr_q == end_cc_pointer);
    // start must be word aligned and the string must not run backwards
    assign job_ok  = !start_cc_pointer[0] && (end_cc_pointer >= start_cc_pointer);

    assign fetch.req  = req_q;
    assign fetch.ch   = word_q.chars[offset];
    assign fetch.last = at_last;

    // error is sticky until rst
    assign error = (state_q == st_error);

    // memory request and job handshake
    always_comb
    begin
        ready        = 1'b0;
        memory_valid = 1'b0;
        memory_addr  = MEM_ADDR_WIDTH'(ptr_q >> $clog2(CHARS_PER_WORD));
        case (state_q)
            st_idle:
            begin
                // first word is requested together with the job
                ready        = memory_ready;
                memory_valid = valid;
                memory_addr  = MEM_ADDR_WIDTH'(start_cc_pointer >> $clog2(CHARS_PER_WORD));
            end
            st_fetch:
            begin
                memory_valid = 1'b1;
            end
            default:
            begin
                memory_valid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q     <= st_idle;
            ptr_q       <= '0;
            req_q       <= 1'b0;
            sent_last_q <= 1'b0;
        end
        else if (job_done && state_q != st_error)
        begin
            // flush, drop any handshake in flight
            state_q     <= st_idle;
            req_q       <= 1'b0;
            sent_last_q <= 1'b0;
        end
        else
        begin
            case (state_q)
                st_idle:
                begin
                    if (valid && memory_ready)
                    begin
                        if (job_ok)
                        begin
                            state_q <= st_wait_data;
                            ptr_q   <= start_cc_pointer;
                        end
                        else
                        begin
                            state_q <= st_error;
                        end
                    end
                end
                st_wait_data:
                begin
                    // memory data is valid now and gets latched below
                    state_q <= st_send;
                end
                st_send:
                begin
                    if (req_q && fetch.ack)
                    begin
                        // character taken, release req
                        req_q <= 1'b0;
                        if (at_last)
                        begin
                            sent_last_q <= 1'b1;
                        end
                        else
                        begin
                            ptr_q <= ptr_q + 1'b1;
                            // all ones offset means the word is used up
                            if (&offset)
                            begin
                                state_q <= st_fetch;
                            end
                        end
                    end
                    else if (!req_q && !fetch.ack && !sent_last_q)
                    begin
                        req_q <= 1'b1;
                    end
                end
                st_fetch:
                begin
                    if (memory_ready)
                    begin
                        state_q <= st_wait_data;
                    end
                end
                default:
                begin
                    state_q <= st_error;
                end
            endcase
        end
    end

    // word register, loaded one cycle after the memory handshake
    always_ff @(posedge clk)
    begin
        if (state_q == st_wait_data)
        begin
            word_q.word <= memory_data.word;
        end
    end

endmodule

//--- verilog/char_fifo.sv
// character FIFO
// buffers up to FIFO_DEPTH characters with their last flags between two
// four-phase links, flush empties it and drops both handshakes
module char_fifo
    import regex_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    char_link_if.sink   in,
    char_link_if.source out
);

    // storage, no reset needed
    logic [CHAR_WIDTH-1:0]              ch_mem   [FIFO_DEPTH];
    logic                               last_mem [FIFO_DEPTH];

    logic [$clog2(FIFO_DEPTH)-1:0]      wr_ptr_q;
    logic [$clog2(FIFO_DEPTH)-1:0]      rd_ptr_q;
    logic [$clog2(FIFO_DEPTH+1)-1:0]    count_q;
    logic                               ack_q;
    logic                               req_q;
    logic                               push;
    logic                               pop;

    // new req on the input side while an entry is free
    assign push = in.req && !ack_q && (count_q < FIFO_DEPTH);
    // sink has acked the head entry
    assign pop  = req_q && out.ack;

    assign in.ack   = ack_q;
    assign out.req  = req_q;
    assign out.ch   = ch_mem[rd_ptr_q];
    assign out.last = last_mem[rd_ptr_q];

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            ack_q    <= 1'b0;
            req_q    <= 1'b0;
        end
        else
        begin
            // input side, ack stays high until req drops
            if (push)
            begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
                ack_q    <= 1'b1;
            end
            else if (ack_q && !in.req)
            begin
                ack_q <= 1'b0;
            end
            // output side, next req only once ack is low again
            if (pop)
            begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
                req_q    <= 1'b0;
            end
            else if (!req_q && !out.ack && count_q != '0)
            begin
                req_q <= 1'b1;
            end
            count_q <= count_q + ($clog2(FIFO_DEPTH+1))'(push)
                               - ($clog2(FIFO_DEPTH+1))'(pop);
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            ch_mem[wr_ptr_q]   <= in.ch;
            last_mem[wr_ptr_q] <= in.last;
        end
    end

endmodule

//--- verilog/pattern_matcher.sv
// literal pattern matcher
// shifts characters into a short history and compares it with a pattern
// of up to PATTERN_LEN_MAX characters, dot matches anything
module pattern_matcher
    import regex_pkg::*;
(
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic [PATTERN_LEN_MAX-1:0][CHAR_WIDTH-1:0]  pattern,
    input  logic [PATTERN_LEN_WIDTH-1:0]                pattern_len,
    output logic                                        done,
    output logic                                        accept,
    char_link_if.sink                                   in
);

    // entry 0 holds the newest character
    logic [PATTERN_LEN_MAX-1:0][CHAR_WIDTH-1:0]     history_q;
    // characters seen, saturates at PATTERN_LEN_MAX
    logic [PATTERN_LEN_WIDTH-1:0]                   seen_q;
    logic                                           ack_q;
    // a new character sits in the history and waits for evaluation
    logic                                           check_q;
    logic                                           last_q;
    logic                                           take;
    logic                                           match;

    assign take   = in.req && !ack_q;
    assign in.ack = ack_q;

    // newest character lines up with pattern[pattern_len-1]
    always_comb
    begin
        logic [PATTERN_LEN_WIDTH-1:0] idx;
        idx   = '0;
        match = (seen_q >= pattern_len);
        for (int i = 0; i < PATTERN_LEN_MAX; i++)
        begin
            if (i < pattern_len)
            begin
                idx = pattern_len - PATTERN_LEN_WIDTH'(i + 1);
                if (pattern[idx] != WILDCARD_CHAR && pattern[idx] != history_q[i])
                begin
                    match = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            seen_q  <= '0;
            ack_q   <= 1'b0;
            check_q <= 1'b0;
            last_q  <= 1'b0;
            done    <= 1'b0;
            accept  <= 1'b0;
        end
        else
        begin
            done   <= 1'b0;
            accept <= 1'b0;
            if (take)
            begin
                ack_q   <= 1'b1;
                check_q <= 1'b1;
                last_q  <= in.last;
                if (seen_q < PATTERN_LEN_MAX)
                begin
                    seen_q <= seen_q + 1'b1;
                end
            end
            else if (ack_q && !in.req)
            begin
                ack_q <= 1'b0;
            end
            // evaluate one cycle after the ack
            if (check_q)
            begin
                check_q <= 1'b0;
                if (match || last_q)
                begin
                    done   <= 1'b1;
                    accept <= match;
                    // empty history for the next job
                    seen_q <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            history_q <= {history_q[PATTERN_LEN_MAX-2:0], in.ch};
        end
    end

endmodule

//--- verilog/regex_coprocessor.sv
// regex coprocessor top level
// fetcher reads the text memory, a character FIFO decouples it from the
// pattern matcher, and the matcher's done flushes the front end
module regex_coprocessor
    import regex_pkg::*;
(
    input  logic                                        clk,
    input  logic                                        rst,

    output logic                                        memory_valid,
    output logic [MEM_ADDR_WIDTH-1:0]                   memory_addr,
    input  logic                                        memory_ready,
    input  logic [MEM_WIDTH-1:0]                        memory_data,

    input  logic                                        valid,
    output logic                                        ready,
    input  logic [PTR_WIDTH-1:0]                        start_cc_pointer,
    input  logic [PTR_WIDTH-1:0]                        end_cc_pointer,

    input  logic [PATTERN_LEN_MAX-1:0][CHAR_WIDTH-1:0]  pattern,
    input  logic [PATTERN_LEN_WIDTH-1:0]                pattern_len,

    output logic                                        done,
    output logic                                        accept,
    output logic                                        error
);

    // fetcher to FIFO, FIFO to matcher
    char_link_if fetch_link ();
    char_link_if match_link ();

    char_fetcher i_char_fetcher (
        .clk              (clk),
        .rst              (rst),
        .valid            (valid),
        .ready            (ready),
        .start_cc_pointer (start_cc_pointer),
        .end_cc_pointer   (end_cc_pointer),
        .memory_valid     (memory_valid),
        .memory_addr      (memory_addr),
        .memory_ready     (memory_ready),
        .memory_data      (memory_data),
        .job_done         (done),
        .error            (error),
        .fetch            (fetch_link.source)
    );

    // done doubles as flush so no stale character survives a job
    char_fifo i_char_fifo (
        .clk   (clk),
        .rst   (rst),
        .flush (done),
        .in    (fetch_link.sink),
        .out   (match_link.source)
    );

    pattern_matcher i_pattern_matcher (
        .clk         (clk),
        .rst         (rst),
        .pattern     (pattern),
        .pattern_len (pattern_len),
        .done        (done),
        .accept      (accept),
        .in          (match_link.sink)
    );

endmodule

//--- verif/text_memory_model.sv
// text memory model for the regex coprocessor testbench
// valid/ready read port with one cycle of read latency
// and optional random stalls on memory_ready
module text_memory_model
    import regex_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stall_enable,
    input  logic                        memory_valid,
    input  logic [MEM_ADDR_WIDTH-1:0]   memory_addr,
    output logic                        memory_ready,
    output logic [MEM_WIDTH-1:0]        memory_data
);
    timeunit 1ns;
    timeprecision 1ps;

    // word array, written directly by the testbench
    logic [MEM_WIDTH-1:0] mem [2**MEM_ADDR_WIDTH];

    initial
    begin
        memory_ready = 1'b1;
        memory_data  = '0;
        // background words carry their full address
        for (int a = 0; a < 2**MEM_ADDR_WIDTH; a++)
        begin
            mem[a] = {5'h15, MEM_ADDR_WIDTH'(a)};
        end
    end

    always @(posedge clk)
    begin
        if (rst)
        begin
            memory_ready <= 1'b1;
            memory_data  <= '0;
        end
        else
        begin
            // data shows up the cycle after the handshake
            if (memory_valid && memory_ready)
            begin
                memory_data <= mem[memory_addr];
            end
            // roughly one stall cycle in four when enabled
            if (stall_enable)
            begin
                memory_ready <= (($urandom % 4) != 0);
            end
            else
            begin
                memory_ready <= 1'b1;
            end
        end
    end

endmodule

//--- verif/regex_coprocessor_tb.sv
// regex coprocessor testbench
// directed jobs against a text memory model, expected accept comes
// from a plain substring search with dot as wildcard
module regex_coprocessor_tb
    import regex_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 20;
    localparam int DRIVE_DELAY     = 2;
    localparam int RESET_CYCLES    = 4;
    localparam int NUM_TESTS       = 6;
    localparam int MAX_CHARS       = 64;
    localparam int CYCLES_PER_CHAR = 40;
    localparam int JOB_CYCLES      = MAX_CHARS * CYCLES_PER_CHAR;
    localparam int WATCHDOG_NS     = NUM_TESTS * JOB_CYCLES * CLK_PERIOD;

    logic                                       clk;
    logic                                       rst;
    logic                                       memory_valid;
    logic [MEM_ADDR_WIDTH-1:0]                  memory_addr;
    logic                                       memory_ready;
    logic [MEM_WIDTH-1:0]                       memory_data;
    logic                                       valid;
    logic                                       ready;
    logic [PTR_WIDTH-1:0]                       start_cc_pointer;
    logic [PTR_WIDTH-1:0]                       end_cc_pointer;
    logic [PATTERN_LEN_MAX-1:0][CHAR_WIDTH-1:0] pattern;
    logic [PATTERN_LEN_WIDTH-1:0]               pattern_len;
    logic                                       done;
    logic                                       accept;
    logic                                       error;
    logic                                       stall_enable;
    int                                         error_count;

    regex_coprocessor i_regex_coprocessor (
        .clk              (clk),
        .rst              (rst),
        .memory_valid     (memory_valid),
        .memory_addr      (memory_addr),
        .memory_ready     (memory_ready),
        .memory_data      (memory_data),
        .valid            (valid),
        .ready            (ready),
        .start_cc_pointer (start_cc_pointer),
        .end_cc_pointer   (end_cc_pointer),
        .pattern          (pattern),
        .pattern_len      (pattern_len),
        .done             (done),
        .accept           (accept),
        .error            (error)
    );

    text_memory_model i_text_memory_model (
        .clk          (clk),
        .rst          (rst),
        .stall_enable (stall_enable),
        .memory_valid (memory_valid),
        .memory_addr  (memory_addr),
        .memory_ready (memory_ready),
        .memory_data  (memory_data)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    // watchdog sized for every test at its longest string
    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not finish in time");
        stop_with_failure();
    end

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual)
        begin
            error_count++;
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
    endtask

    // character at pointer p sits in word p/2, byte p%2
    task automatic load_text(int base, string text);
        int addr;
        for (int i = 0; i < text.len(); i++)
        begin
            addr = base + i;
            i_text_memory_model.mem[addr / 2][(addr % 2) * 8 +: 8] = text[i];
        end
    endtask

    // reference rule, pattern anywhere in text[first..last], dot matches all
    function automatic logic expected_accept(string text, int first, int last, string pat);
        logic found;
        logic hit;
        found = 1'b0;
        for (int i = first; i + pat.len() - 1 <= last; i++)
        begin
            hit = 1'b1;
            for (int j = 0; j < pat.len(); j++)
            begin
                if (pat[j] != "." && pat[j] != text[i + j])
                begin
                    hit = 1'b0;
                end
            end
            if (hit)
            begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // present one job and hold valid until ready is seen
    task automatic start_job(string name, int first, int last, string pat);
        int cycles;
        @(posedge clk);
        #DRIVE_DELAY;
        start_cc_pointer = first;
        end_cc_pointer   = last;
        pattern          = '0;
        for (int j = 0; j < pat.len(); j++)
        begin
            pattern[j] = pat[j];
        end
        pattern_len = PATTERN_LEN_WIDTH'(pat.len());
        valid       = 1'b1;
        cycles      = 0;
        @(negedge clk);
        while (!ready)
        begin
            cycles++;
            if (cycles > JOB_CYCLES)
            begin
                $display("job was never accepted, ready stayed low");
                stop_with_failure();
            end
            @(negedge clk);
        end
        // first word is requested in the cycle the job is taken
        check_value({name, " first read"}, 32'd1, 32'(memory_valid));
        check_value({name, " first addr"}, 32'(first / CHARS_PER_WORD), 32'(memory_addr));
        @(posedge clk);
        #DRIVE_DELAY;
        valid = 1'b0;
    endtask

    // sample mid cycle until done or error shows up
    task automatic wait_for_result(output logic got_done, output logic got_accept,
                                   output logic got_error);
        int cycles;
        got_done   = 1'b0;
        got_accept = 1'b0;
        got_error  = 1'b0;
        cycles     = 0;
        while (!got_done && !got_error)
        begin
            @(negedge clk);
            if (done)
            begin
                got_done   = 1'b1;
                got_accept = accept;
            end
            got_error = error;
            cycles++;
            if (cycles > JOB_CYCLES)
            begin
                $display("no done and no error arrived for the running job");
                stop_with_failure();
            end
        end
    endtask

    task automatic run_match_job(string name, int base, string text, int first, int last,
                                 string pat);
        logic got_done;
        logic got_accept;
        logic got_error;
        start_job(name, base + first, base + last, pat);
        wait_for_result(got_done, got_accept, got_error);
        check_value({name, " error"}, 32'd0, 32'(got_error));
        check_value({name, " accept"}, 32'(expected_accept(text, first, last, pat)),
                    32'(got_accept));
    endtask

    task automatic test_middle_match();
        load_text(16, "abcdefgh1234ijklmnop");
        run_match_job("middle_match", 16, "abcdefgh1234ijklmnop", 0, 19, "1234");
    endtask

    task automatic test_no_match();
        load_text(64, "the rain in spain st");
        run_match_job("no_match", 64, "the rain in spain st", 0, 19, "plan");
        // job interface free again the cycle after done
        @(negedge clk);
        check_value("no_match ready", 32'd1, 32'(ready));
    endtask

    task automatic test_wildcard_and_single();
        load_text(128, "a cut above");
        run_match_job("wildcard", 128, "a cut above", 0, 10, "c.t");
        load_text(160, "hello world!");
        run_match_job("single_char", 160, "hello world!", 0, 11, "!");
    endtask

    // 17 characters, the last one alone in the low byte of its word
    task automatic test_stalled_boundary();
        stall_enable = 1'b1;
        load_text(200, "abcdefghijklmnopq");
        run_match_job("stalled_boundary", 200, "abcdefghijklmnopq", 0, 16, "nopq");
        stall_enable = 1'b0;
    endtask

    // second job starts past the first match, stale y chars would fake a hit
    task automatic test_back_to_back();
        load_text(400, "xxabcdyyyyzzzzwwwwab");
        run_match_job("back_to_back first", 400, "xxabcdyyyyzzzzwwwwab", 0, 19, "abcd");
        run_match_job("back_to_back second", 400, "xxabcdyyyyzzzzwwwwab", 10, 19, "yzzz");
    endtask

    task automatic test_error_then_reset();
        logic got_done;
        logic got_accept;
        logic got_error;
        start_job("odd_start", 301, 310, "ab");
        wait_for_result(got_done, got_accept, got_error);
        check_value("odd_start error", 32'd1, 32'(got_error));
        check_value("odd_start done", 32'd0, 32'(got_done));
        repeat (8)
        begin
            @(negedge clk);
            check_value("odd_start no done", 32'd0, 32'(done));
        end
        apply_reset();
        @(negedge clk);
        check_value("odd_start error after rst", 32'd0, 32'(error));
        check_value("odd_start done after rst", 32'd0, 32'(done));
    endtask

    initial
    begin
        rst              = 1'b1;
        valid            = 1'b0;
        start_cc_pointer = '0;
        end_cc_pointer   = '0;
        pattern          = '0;
        pattern_len      = '0;
        stall_enable     = 1'b0;
        error_count      = 0;
        void'($urandom(32'h4b576e5b));
        apply_reset();
        test_middle_match();
        test_no_match();
        test_wildcard_and_single();
        test_stalled_boundary();
        test_back_to_back();
        test_error_then_reset();
        if (error_count == 0)
        begin
            $display("All tests passed");
            $finish;
        end
        else
        begin
            stop_with_failure();
        end
    end

endmodule

//--- compile.f
verilog/regex_pkg.sv
verilog/char_link_if.sv
verilog/char_fetcher.sv
verilog/char_fifo.sv
verilog/pattern_matcher.sv
verilog/regex_coprocessor.sv
verif/text_memory_model.sv
verif/regex_coprocessor_tb.sv

//--- Bender.yml
package:
  name: regex_coprocessor

sources:
  - verilog/regex_pkg.sv
  - verilog/char_link_if.sv
  - verilog/char_fetcher.sv
  - verilog/char_fifo.sv
  - verilog/pattern_matcher.sv
  - verilog/regex_coprocessor.sv
  - target: test
    files:
      - verif/text_memory_model.sv
      - verif/regex_coprocessor_tb.sv
